/* hdl/ttc_config.svh */
// ------------------------------------------------
// widths and reset values for the lite TTC channel
// the prescaler needs a data width of at least 16
// ------------------------------------------------

`ifndef TTC_CONFIG_SVH
`define TTC_CONFIG_SVH

// counter and register data width
`define TTC_DATA_W 16

// word address width on paddr
`define TTC_ADDR_W 4

// counter-control reset value
// only count_disable set, so the channel comes up stopped
`define TTC_CNTR_CTRL_RST 5'h01

`endif

/* hdl/ttc_pkg.sv */
// ------------------------------------------------
// types shared by the lite TTC channel
// bit maps below are documentation only, no types
// ------------------------------------------------
`default_nettype none

`include "ttc_config.svh"

package ttc_pkg;

  // one data word, counter and registers
  typedef logic [`TTC_DATA_W-1:0] ttc_data_t;

  // register word addresses
  typedef enum logic [3:0] {
    REG_CLK_CTRL    = 4'd0,
    REG_CNTR_CTRL   = 4'd1,
    REG_COUNTER_VAL = 4'd2,  // read only
    REG_INTERVAL    = 4'd3,
    REG_MATCH       = 4'd4,
    REG_INT_STATUS  = 4'd5,  // clears on read
    REG_INT_ENABLE  = 4'd6
  } ttc_reg_addr_e;

  // counter sequencing states
  typedef enum logic [1:0] {
    CNT_IDLE   = 2'd0,
    CNT_RELOAD = 2'd1,
    CNT_RUN    = 2'd2
  } ttc_cnt_state_e;

  // counter control: 0 count_disable, 1 interval_mode, 2 decrement,
  //   3 match_enable, 4 restart
  // clock control: 0 prescale enable, 4:1 prescale value N, 6:5 unused
  // interrupts: 0 interval, 1 match, 2 overflow

endpackage

`default_nettype wire

/* hdl/ttc_count_rst_lite.sv */
// ------------------------------------------------
// clock-control register and restart pulse
// restart must drop low before it can restart again
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ttc_count_rst_lite (
  input  wire        n_p_reset13,
  input  wire        pclk13,
  input  wire  [6:0] pwdata,
  input  wire        clk_ctrl_reg_sel,
  input  wire        restart,
  output logic       count_en_out,
  output logic [6:0] clk_ctrl_reg_out
);

  // restart already acted on, wait for it to go low
  logic restart_seen;

  // ------------------------------------------------
  // count enable generation
  // ------------------------------------------------

  // low out of reset, high from the first edge after
  always_ff @(posedge pclk13 or negedge n_p_reset13)
  begin
    if (!n_p_reset13)
    begin
      restart_seen <= 1'b0;
      count_en_out <= 1'b0;
    end
    else if (restart && !restart_seen)
    begin
      // rising restart, drop enable one cycle
      restart_seen <= 1'b1;
      count_en_out <= 1'b0;
    end
    else
    begin
      // rearm once restart is released
      if (!restart)
        restart_seen <= 1'b0;
      count_en_out <= 1'b1;
    end
  end

  // ------------------------------------------------
  // clock-control register
  // ------------------------------------------------

  // bits 6:5 kept for readback only
  always_ff @(posedge pclk13 or negedge n_p_reset13)
  begin
    if (!n_p_reset13)
      clk_ctrl_reg_out <= 7'h00;
    else if (clk_ctrl_reg_sel)
      clk_ctrl_reg_out <= pwdata;
  end

endmodule

`default_nettype wire

/* hdl/ttc_prescaler.sv */
// ------------------------------------------------
// power-of-two prescaler, period 2^(N+1) when enabled
// external clock select bits are ignored
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ttc_config.svh"

module ttc_prescaler (
  input  wire        n_p_reset13,
  input  wire        pclk13,
  input  wire  [6:0] clk_ctrl,
  input  wire        count_en,
  input  wire        run,
  output logic       tick
);

  // one bit wider than data so 2^16 - 1 fits
  localparam int PS_W = `TTC_DATA_W + 1;

  logic            ps_en;
  logic [3:0]      ps_val;
  logic [PS_W-1:0] ps_cnt;
  logic [PS_W-1:0] ps_last;

  // clock-control fields
  assign ps_en  = clk_ctrl[0];
  assign ps_val = clk_ctrl[4:1];

  // terminal count 2^(N+1) - 1
  assign ps_last = (PS_W'(1) << (ps_val + 5'd1)) - PS_W'(1);

  // prescale off, tick every running cycle
  assign tick = ps_en ? (run && (ps_cnt == ps_last)) : run;

  // ------------------------------------------------
  // prescale count
  // ------------------------------------------------
  always_ff @(posedge pclk13 or negedge n_p_reset13)
  begin
    if (!n_p_reset13)
      ps_cnt <= '0;
    else if (!count_en || !run || !ps_en)
      // restart phase on reload or while stopped
      ps_cnt <= '0;
    else if (ps_cnt == ps_last)
      ps_cnt <= '0;
    else
      ps_cnt <= ps_cnt + PS_W'(1);
  end

endmodule

`default_nettype wire

/* hdl/ttc_counter_ctrl.sv */
// ------------------------------------------------
// counter sequencing FSM, idle / reload / run
// reload always lasts exactly one cycle
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ttc_counter_ctrl (
  input  wire                     n_p_reset13,
  input  wire                     pclk13,
  input  wire                     count_en,
  input  wire                     count_disable,
  input  wire                     tick,
  output ttc_pkg::ttc_cnt_state_e state,
  output logic                    run,
  output logic                    load,
  output logic                    step
);

  import ttc_pkg::*;

  ttc_cnt_state_e state_nxt;

  // ------------------------------------------------
  // next state
  // ------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    if (count_disable)
      // disabled wins over everything
      state_nxt = CNT_IDLE;
    else if (!count_en)
      // restart drop, reload from scratch
      state_nxt = CNT_RELOAD;
    else
    begin
      case (state)
        CNT_IDLE:   state_nxt = CNT_RELOAD;
        CNT_RELOAD: state_nxt = CNT_RUN;
        CNT_RUN:    state_nxt = CNT_RUN;
        default:    state_nxt = CNT_IDLE;
      endcase
    end
  end

  // state register
  always_ff @(posedge pclk13 or negedge n_p_reset13)
  begin
    if (!n_p_reset13)
      state <= CNT_IDLE;
    else
      state <= state_nxt;
  end

  // ------------------------------------------------
  // outputs, decoded from state
  // ------------------------------------------------

  // load for the single reload cycle
  assign load = (state == CNT_RELOAD);

  // prescaler runs only here
  assign run = (state == CNT_RUN);

  // each tick moves the counter by one
  assign step = run && tick;

endmodule

`default_nettype wire

/* hdl/ttc_counter.sv */
// ------------------------------------------------
// 16-bit up/down counter with interval wrap
// event pulses are one cycle, with the value update
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ttc_counter (
  input  wire                     n_p_reset13,
  input  wire                     pclk13,
  input  ttc_pkg::ttc_cnt_state_e state,
  input  wire                     load,
  input  wire                     step,
  input  wire                     interval_mode,
  input  wire                     decrement,
  input  wire                     match_enable,
  input  ttc_pkg::ttc_data_t      interval_val,
  input  ttc_pkg::ttc_data_t      match_val,
  output ttc_pkg::ttc_data_t      count_val,
  output logic                    interval_evt,
  output logic                    match_evt,
  output logic                    overflow_evt
);

  import ttc_pkg::*;

  ttc_data_t load_val;
  ttc_data_t nxt_val;
  logic      nxt_int;
  logic      nxt_ovf;
  logic      adv;

  // start point, down counts begin at the top
  assign load_val = decrement ? (interval_mode ? interval_val : '1) : '0;

  // only advance while running
  assign adv = step && (state == CNT_RUN);

  // ------------------------------------------------
  // next value and wrap events
  // ------------------------------------------------
  always_comb
  begin
    nxt_val = count_val;
    nxt_int = 1'b0;
    nxt_ovf = 1'b0;
    if (decrement)
    begin
      if (count_val == '0)
      begin
        if (interval_mode)
        begin
          nxt_val = interval_val;
          nxt_int = 1'b1;
        end
        else
        begin
          nxt_val = '1;
          nxt_ovf = 1'b1;
        end
      end
      else
        nxt_val = count_val - 1'b1;
    end
    else
    begin
      if (interval_mode && (count_val == interval_val))
      begin
        nxt_val = '0;
        nxt_int = 1'b1;
      end
      else if (count_val == '1)
      begin
        nxt_val = '0;
        nxt_ovf = 1'b1;
      end
      else
        nxt_val = count_val + 1'b1;
    end
  end

  // ------------------------------------------------
  // value and event registers
  // ------------------------------------------------
  always_ff @(posedge pclk13 or negedge n_p_reset13)
  begin
    if (!n_p_reset13)
    begin
      count_val    <= '0;
      interval_evt <= 1'b0;
      match_evt    <= 1'b0;
      overflow_evt <= 1'b0;
    end
    else
    begin
      // pulses by default
      interval_evt <= 1'b0;
      match_evt    <= 1'b0;
      overflow_evt <= 1'b0;
      if (load)
        count_val <= load_val;
      else if (adv)
      begin
        count_val    <= nxt_val;
        interval_evt <= nxt_int;
        overflow_evt <= nxt_ovf;
        // match on the value being entered
        match_evt    <= match_enable && (nxt_val == match_val);
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ttc_reg_file.sv */
// ------------------------------------------------
// APB register file, no wait states, no pslverr
// status is sticky and clears on read
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ttc_config.svh"

module ttc_reg_file (
  input  wire                      n_p_reset13,
  input  wire                      pclk13,
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  wire  [`TTC_ADDR_W-1:0]   paddr,
  input  ttc_pkg::ttc_data_t       pwdata,
  output ttc_pkg::ttc_data_t       prdata,
  output logic                     clk_ctrl_reg_sel,
  input  wire  [6:0]               clk_ctrl,
  input  ttc_pkg::ttc_data_t       count_val,
  input  wire                      interval_evt,
  input  wire                      match_evt,
  input  wire                      overflow_evt,
  output logic                     restart,
  output logic                     count_disable,
  output logic                     interval_mode,
  output logic                     decrement,
  output logic                     match_enable,
  output ttc_pkg::ttc_data_t       interval_val,
  output ttc_pkg::ttc_data_t       match_val,
  output logic                     irq
);

  import ttc_pkg::*;

  ttc_reg_addr_e addr;
  logic          wr_en;
  logic          rd_en;
  logic [4:0]    cntr_ctrl;
  logic [2:0]    int_enable;
  logic [2:0]    int_status;
  logic [2:0]    int_evts;

  // ------------------------------------------------
  // bus decode
  // ------------------------------------------------
  assign addr  = ttc_reg_addr_e'(paddr);
  assign wr_en = psel && penable && pwrite;
  assign rd_en = psel && penable && !pwrite;

  // clock-control lives in the restart block
  assign clk_ctrl_reg_sel = wr_en && (addr == REG_CLK_CTRL);

  // counter-control fields
  assign count_disable = cntr_ctrl[0];
  assign interval_mode = cntr_ctrl[1];
  assign decrement     = cntr_ctrl[2];
  assign match_enable  = cntr_ctrl[3];
  assign restart       = cntr_ctrl[4];

  // ------------------------------------------------
  // writable registers
  // ------------------------------------------------
  always_ff @(posedge pclk13 or negedge n_p_reset13)
  begin
    if (!n_p_reset13)
    begin
      cntr_ctrl    <= `TTC_CNTR_CTRL_RST;
      interval_val <= '0;
      match_val    <= '0;
      int_enable   <= 3'b000;
    end
    else if (wr_en)
    begin
      case (addr)
        REG_CNTR_CTRL:  cntr_ctrl    <= pwdata[4:0];
        REG_INTERVAL:   interval_val <= pwdata;
        REG_MATCH:      match_val    <= pwdata;
        REG_INT_ENABLE: int_enable   <= pwdata[2:0];
        default:        ;
      endcase
    end
  end

  // ------------------------------------------------
  // sticky status and irq
  // ------------------------------------------------

  // bit order interval, match, overflow
  assign int_evts = {overflow_evt, match_evt, interval_evt};

  // clear on read, a same-edge event still lands
  always_ff @(posedge pclk13 or negedge n_p_reset13)
  begin
    if (!n_p_reset13)
    begin
      int_status <= 3'b000;
      irq        <= 1'b0;
    end
    else
    begin
      if (rd_en && (addr == REG_INT_STATUS))
        int_status <= int_evts;
      else
        int_status <= int_status | int_evts;
      irq <= |(int_status & int_enable);
    end
  end

  // ------------------------------------------------
  // readback mux, unused bits and addresses read 0
  // ------------------------------------------------
  always_comb
  begin
    prdata = '0;
    if (psel && !pwrite)
    begin
      case (addr)
        REG_CLK_CTRL:    prdata[6:0] = clk_ctrl;
        REG_CNTR_CTRL:   prdata[4:0] = cntr_ctrl;
        REG_COUNTER_VAL: prdata      = count_val;
        REG_INTERVAL:    prdata      = interval_val;
        REG_MATCH:       prdata      = match_val;
        REG_INT_STATUS:  prdata[2:0] = int_status;
        REG_INT_ENABLE:  prdata[2:0] = int_enable;
        default:         prdata      = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/ttc_lite_top.sv */
// ------------------------------------------------
// single-channel lite TTC, always clocked by pclk13
// no wave output, no pready or pslverr
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ttc_config.svh"

module ttc_lite_top (
  input  wire                    n_p_reset13,
  input  wire                    pclk13,
  input  wire                    psel,
  input  wire                    penable,
  input  wire                    pwrite,
  input  wire  [`TTC_ADDR_W-1:0] paddr,
  input  ttc_pkg::ttc_data_t     pwdata,
  output ttc_pkg::ttc_data_t     prdata,
  output logic                   irq
);

  import ttc_pkg::*;

  // register file to restart block
  logic           clk_ctrl_reg_sel;
  logic [6:0]     clk_ctrl;
  logic           count_en;

  // counter-control fields
  logic           restart;
  logic           count_disable;
  logic           interval_mode;
  logic           decrement;
  logic           match_enable;
  ttc_data_t      interval_val;
  ttc_data_t      match_val;

  // sequencing
  ttc_cnt_state_e state;
  logic           run;
  logic           load;
  logic           step;
  logic           tick;

  // counter results
  ttc_data_t      count_val;
  logic           interval_evt;
  logic           match_evt;
  logic           overflow_evt;

  // ------------------------------------------------
  // bus side
  // ------------------------------------------------
  ttc_reg_file u_reg_file (
    .n_p_reset13      (n_p_reset13),
    .pclk13           (pclk13),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .clk_ctrl_reg_sel (clk_ctrl_reg_sel),
    .clk_ctrl         (clk_ctrl),
    .count_val        (count_val),
    .interval_evt     (interval_evt),
    .match_evt        (match_evt),
    .overflow_evt     (overflow_evt),
    .restart          (restart),
    .count_disable    (count_disable),
    .interval_mode    (interval_mode),
    .decrement        (decrement),
    .match_enable     (match_enable),
    .interval_val     (interval_val),
    .match_val        (match_val),
    .irq              (irq)
  );

  ttc_count_rst_lite u_count_rst (
    .n_p_reset13      (n_p_reset13),
    .pclk13           (pclk13),
    .pwdata           (pwdata[6:0]),
    .clk_ctrl_reg_sel (clk_ctrl_reg_sel),
    .restart          (restart),
    .count_en_out     (count_en),
    .clk_ctrl_reg_out (clk_ctrl)
  );

  // ------------------------------------------------
  // timer side
  // ------------------------------------------------
  ttc_prescaler u_prescaler (
    .n_p_reset13 (n_p_reset13),
    .pclk13      (pclk13),
    .clk_ctrl    (clk_ctrl),
    .count_en    (count_en),
    .run         (run),
    .tick        (tick)
  );

  ttc_counter_ctrl u_counter_ctrl (
    .n_p_reset13   (n_p_reset13),
    .pclk13        (pclk13),
    .count_en      (count_en),
    .count_disable (count_disable),
    .tick          (tick),
    .state         (state),
    .run           (run),
    .load          (load),
    .step          (step)
  );

  ttc_counter u_counter (
    .n_p_reset13   (n_p_reset13),
    .pclk13        (pclk13),
    .state         (state),
    .load          (load),
    .step          (step),
    .interval_mode (interval_mode),
    .decrement     (decrement),
    .match_enable  (match_enable),
    .interval_val  (interval_val),
    .match_val     (match_val),
    .count_val     (count_val),
    .interval_evt  (interval_evt),
    .match_evt     (match_evt),
    .overflow_evt  (overflow_evt)
  );

endmodule

`default_nettype wire

/* verification/tb_ttc_lite.sv */
// ------------------------------------------------
// directed testbench for the lite TTC channel
// rate checks allow a few cycles of bus latency
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ttc_config.svh"

module tb_ttc_lite;

  import ttc_pkg::*;

  logic                   pclk13;
  logic                   n_p_reset13;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`TTC_ADDR_W-1:0] paddr;
  ttc_data_t              pwdata;
  ttc_data_t              prdata;
  logic                   irq;

  int          errors;
  logic [31:0] lcg_state;

  ttc_lite_top UUT (
    .n_p_reset13 (n_p_reset13),
    .pclk13      (pclk13),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .irq         (irq)
  );

  // 4 ns period
  always #2 pclk13 = ~pclk13;

  // ------------------------------------------------
  // helpers
  // ------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // setup phase, access phase, write lands on the last edge
  task automatic apb_write(input ttc_reg_addr_e addr, input ttc_data_t data);
    @(posedge pclk13);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge pclk13);
    penable <= 1'b1;
    @(posedge pclk13);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  // sampled mid access phase, before any clear-on-read edge
  task automatic apb_read(input ttc_reg_addr_e addr, output ttc_data_t data);
    @(posedge pclk13);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge pclk13);
    penable <= 1'b1;
    @(negedge pclk13);
    data = prdata;
    @(posedge pclk13);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_data(input string name, input ttc_data_t exp, input ttc_data_t act);
    if (act !== exp)
    begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  // inclusive window
  task automatic check_range(input string name, input ttc_data_t lo, input ttc_data_t hi,
                             input ttc_data_t act);
    if (act < lo || act > hi)
    begin
      $display("ERROR %s: expected %h..%h, actual %h", name, lo, hi, act);
      errors++;
    end
  endtask

  task automatic wait_irq(input string name, input logic level, input int timeout);
    int n;
    n = 0;
    @(negedge pclk13);
    while (irq !== level && n < timeout)
    begin
      @(negedge pclk13);
      n++;
    end
    if (irq !== level)
    begin
      $display("%s: irq did not go to %b within %0d cycles", name, level, timeout);
      errors++;
    end
  endtask

  // repeated counter reads until the value drops under limit
  task automatic poll_count_below(input string name, input ttc_data_t limit,
                                  input int max_reads);
    ttc_data_t val;
    int        n;
    logic      found;
    n     = 0;
    found = 1'b0;
    while (!found && n < max_reads)
    begin
      apb_read(REG_COUNTER_VAL, val);
      n++;
      if (val < limit)
        found = 1'b1;
    end
    if (!found)
    begin
      $display("%s: counter not reloaded after %0d reads, last value %h", name, n, val);
      errors++;
    end
  endtask

  // ------------------------------------------------
  // tests
  // ------------------------------------------------
  task automatic test_reset();
    ttc_data_t val;
    apb_read(REG_CLK_CTRL, val);
    check_data("reset clk_ctrl", 16'h0000, val);
    apb_read(REG_CNTR_CTRL, val);
    check_data("reset cntr_ctrl", ttc_data_t'(`TTC_CNTR_CTRL_RST), val);
    apb_read(REG_COUNTER_VAL, val);
    check_data("reset counter", 16'h0000, val);
    // disabled, so nothing moves
    repeat (20) @(posedge pclk13);
    apb_read(REG_COUNTER_VAL, val);
    check_data("reset counter held", 16'h0000, val);
    apb_read(REG_INT_STATUS, val);
    check_data("reset int_status", 16'h0000, val);
    @(negedge pclk13);
    check_bit("reset irq", 1'b0, irq);
  endtask

  task automatic test_readback();
    ttc_data_t wr;
    ttc_data_t val;
    wr = ttc_data_t'(lcg_next());
    apb_write(REG_CLK_CTRL, wr);
    apb_read(REG_CLK_CTRL, val);
    check_data("readback clk_ctrl", {9'd0, wr[6:0]}, val);
    wr = ttc_data_t'(lcg_next());
    apb_write(REG_INTERVAL, wr);
    apb_read(REG_INTERVAL, val);
    check_data("readback interval", wr, val);
    wr = ttc_data_t'(lcg_next());
    apb_write(REG_MATCH, wr);
    apb_read(REG_MATCH, val);
    check_data("readback match", wr, val);
    wr = ttc_data_t'(lcg_next());
    apb_write(REG_INT_ENABLE, wr);
    apb_read(REG_INT_ENABLE, val);
    check_data("readback int_enable", {13'd0, wr[2:0]}, val);
    // keep count_disable set so the counter stays stopped
    wr = ttc_data_t'(lcg_next() | 32'h1);
    apb_write(REG_CNTR_CTRL, wr);
    apb_read(REG_CNTR_CTRL, val);
    check_data("readback cntr_ctrl", {11'd0, wr[4:0]}, val);
    // back to a quiet channel
    apb_write(REG_CNTR_CTRL, 16'h0001);
    apb_write(REG_CLK_CTRL, 16'h0000);
    apb_write(REG_INT_ENABLE, 16'h0000);
  endtask

  task automatic test_rate();
    ttc_data_t a;
    ttc_data_t b;
    // up counting, one tick per cycle
    apb_write(REG_CNTR_CTRL, 16'h0000);
    apb_read(REG_COUNTER_VAL, a);
    // 3 edges of bus overhead, so samples sit 40 cycles apart
    repeat (37) @(posedge pclk13);
    apb_read(REG_COUNTER_VAL, b);
    check_range("rate no prescale", 16'd37, 16'd43, b - a);
    // N = 1, one tick every 4 cycles
    apb_write(REG_CLK_CTRL, 16'h0003);
    apb_read(REG_COUNTER_VAL, a);
    repeat (37) @(posedge pclk13);
    apb_read(REG_COUNTER_VAL, b);
    check_range("rate prescale 1", 16'd8, 16'd12, b - a);
    apb_write(REG_CNTR_CTRL, 16'h0001);
    apb_write(REG_CLK_CTRL, 16'h0000);
  endtask

  task automatic test_interval();
    ttc_data_t val;
    apb_write(REG_INTERVAL, 16'd20);
    apb_write(REG_INT_ENABLE, 16'h0001);
    apb_read(REG_INT_STATUS, val);
    // interval mode plus decrement, enabled
    apb_write(REG_CNTR_CTRL, 16'h0006);
    repeat (8)
    begin
      apb_read(REG_COUNTER_VAL, val);
      check_range("interval bound", 16'd0, 16'd20, val);
      repeat (3) @(posedge pclk13);
    end
    wait_irq("interval irq", 1'b1, 200);
    apb_read(REG_INT_STATUS, val);
    check_bit("interval status bit0", 1'b1, val[0]);
    apb_write(REG_CNTR_CTRL, 16'h0001);
    apb_read(REG_INT_STATUS, val);
    wait_irq("interval irq clear", 1'b0, 20);
  endtask

  task automatic test_match();
    ttc_data_t val;
    apb_write(REG_MATCH, 16'd30);
    apb_write(REG_INT_ENABLE, 16'h0002);
    // up counting with match enabled
    apb_write(REG_CNTR_CTRL, 16'h0008);
    wait_irq("match irq", 1'b1, 200);
    apb_read(REG_INT_STATUS, val);
    check_bit("match status bit1", 1'b1, val[1]);
    apb_write(REG_CNTR_CTRL, 16'h0001);
    apb_read(REG_INT_STATUS, val);
    check_data("match status cleared", 16'h0000, val);
    wait_irq("match irq clear", 1'b0, 20);
  endtask

  task automatic test_restart();
    ttc_data_t first;
    ttc_data_t val;
    apb_write(REG_INT_ENABLE, 16'h0000);
    apb_write(REG_CNTR_CTRL, 16'h0000);
    repeat (200) @(posedge pclk13);
    apb_read(REG_COUNTER_VAL, val);
    check_range("restart large count", 16'd150, 16'hffff, val);
    // restart set, reload lands 3 edges after the write
    apb_write(REG_CNTR_CTRL, 16'h0010);
    poll_count_below("restart first", 16'd6, 2);
    apb_read(REG_COUNTER_VAL, first);
    // restart still high, counting continues
    repeat (50) @(posedge pclk13);
    apb_read(REG_COUNTER_VAL, val);
    check_range("restart held", first + 16'd40, 16'hffff, val);
    apb_write(REG_CNTR_CTRL, 16'h0000);
    apb_write(REG_CNTR_CTRL, 16'h0010);
    poll_count_below("restart again", 16'd6, 2);
    apb_write(REG_CNTR_CTRL, 16'h0001);
  endtask

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------
  initial
  begin
    pclk13      = 1'b0;
    n_p_reset13 = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    errors      = 0;
    lcg_state   = 32'h26215a39;
    repeat (2) @(posedge pclk13);
    n_p_reset13 <= 1'b1;
    @(posedge pclk13);

    test_reset();
    test_readback();
    test_rate();
    test_interval();
    test_match();
    test_restart();

    $display("checks done, %0d errors", errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+hdl
hdl/ttc_pkg.sv
hdl/ttc_count_rst_lite.sv
hdl/ttc_prescaler.sv
hdl/ttc_counter_ctrl.sv
hdl/ttc_counter.sv
hdl/ttc_reg_file.sv
hdl/ttc_lite_top.sv
verification/tb_ttc_lite.sv
